// File: design/mempool_cluster.sv
// Four-group shared TCDM cluster
// One requester port and one bank per group, joined by request and response
// crossbars over local, east, north and northeast links

`timescale 1ns/1ps

module mempool_cluster
  import mempool_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Per-group requester ports
  input  logic                 req_valid_i  [NumGroups],
  output logic                 req_ready_o  [NumGroups],
  input  tcdm_addr_t           req_addr_i   [NumGroups],
  input  logic                 req_wen_i    [NumGroups],
  input  logic [DataWidth-1:0] req_wdata_i  [NumGroups],
  output logic                 resp_valid_o [NumGroups],
  output logic [DataWidth-1:0] resp_rdata_o [NumGroups]
);

  logic                     bank_gnt   [NumGroups];
  logic [GroupIdxWidth-1:0] bank_route [NumGroups];
  logic                     bank_en    [NumGroups];
  logic                     bank_we    [NumGroups];
  logic [RowWidth-1:0]      bank_row   [NumGroups];
  logic [DataWidth-1:0]     bank_wdata [NumGroups];
  logic [DataWidth-1:0]     bank_rdata [NumGroups];
  logic [GroupIdxWidth-1:0] resp_bank  [NumGroups];

  tcdm_arbiter i_arbiter (
    .clk_i       (clk_i       ),
    .rst_i       (rst_i       ),
    .req_valid_i (req_valid_i ),
    .req_addr_i  (req_addr_i  ),
    .req_wen_i   (req_wen_i   ),
    .req_ready_o (req_ready_o ),
    .bank_gnt_o  (bank_gnt    ),
    .bank_route_o(bank_route  ),
    .resp_valid_o(resp_valid_o),
    .resp_bank_o (resp_bank   )
  );

  // Route code picks the link, xor of source and bank
  tcdm_req_xbar i_req_xbar (
    .req_addr_i  (req_addr_i ),
    .req_wen_i   (req_wen_i  ),
    .req_wdata_i (req_wdata_i),
    .bank_gnt_i  (bank_gnt   ),
    .bank_route_i(bank_route ),
    .bank_en_o   (bank_en    ),
    .bank_we_o   (bank_we    ),
    .bank_row_o  (bank_row   ),
    .bank_wdata_o(bank_wdata )
  );

  for (genvar g = 0; g < NumGroups; g++) begin : gen_banks
    tcdm_bank i_bank (
      .clk_i  (clk_i        ),
      .en_i   (bank_en[g]   ),
      .we_i   (bank_we[g]   ),
      .row_i  (bank_row[g]  ),
      .wdata_i(bank_wdata[g]),
      .rdata_o(bank_rdata[g])
    );
  end : gen_banks

  tcdm_resp_xbar i_resp_xbar (
    .bank_rdata_i(bank_rdata  ),
    .resp_bank_i (resp_bank   ),
    .resp_rdata_o(resp_rdata_o)
  );

endmodule : mempool_cluster

// File: design/mempool_pkg.sv
// Shared constants and address type for the four-group TCDM cluster
// Word addresses interleave across banks on the two lowest bits

package mempool_pkg;

  // Cluster shape
  localparam int unsigned NumGroups     = 4;
  localparam int unsigned GroupIdxWidth = 2;

  // Bank geometry
  localparam int unsigned RowsPerBank = 64;
  localparam int unsigned RowWidth    = 6;

  // Word address covers all banks
  localparam int unsigned AddrWidth = RowWidth + GroupIdxWidth;
  localparam int unsigned DataWidth = 32;

  // Decoded view, row on top and bank select in the low bits
  typedef struct packed {
    logic [RowWidth-1:0]      row;
    logic [GroupIdxWidth-1:0] group;
  } tcdm_addr_fields_t;

  // Same word seen flat or decoded
  typedef union packed {
    logic [AddrWidth-1:0] word;
    tcdm_addr_fields_t    f;
  } tcdm_addr_t;

endpackage : mempool_pkg

// File: design/tcdm_arbiter.sv
// TCDM control block
// Decodes each port's target bank, grants one source per bank in round-robin
// order and keeps the per-port response route for the following cycle

`timescale 1ns/1ps

module tcdm_arbiter
  import mempool_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     req_valid_i  [NumGroups],
  input  tcdm_addr_t               req_addr_i   [NumGroups],
  input  logic                     req_wen_i    [NumGroups],
  output logic                     req_ready_o  [NumGroups],
  output logic                     bank_gnt_o   [NumGroups],
  output logic [GroupIdxWidth-1:0] bank_route_o [NumGroups],
  output logic                     resp_valid_o [NumGroups],
  output logic [GroupIdxWidth-1:0] resp_bank_o  [NumGroups]
);

  logic [GroupIdxWidth-1:0] tgt         [NumGroups];
  logic [GroupIdxWidth-1:0] bank_src    [NumGroups];
  logic [GroupIdxWidth-1:0] ptr_q       [NumGroups];
  logic                     resp_pend_q [NumGroups];
  logic                     resp_rd_q   [NumGroups];
  logic [GroupIdxWidth-1:0] resp_bank_q [NumGroups];
  logic [NumGroups-1:0]     bank_acc    [NumGroups];

  // Target bank straight from the decoded address
  for (genvar p = 0; p < NumGroups; p++) begin : gen_decode
    assign tgt[p] = req_addr_i[p].f.group;
  end : gen_decode

  // Round-robin scan from each bank's pointer
  always_comb begin
    logic [GroupIdxWidth-1:0] cand;
    cand = '0;
    for (int b = 0; b < NumGroups; b++) begin
      bank_gnt_o[b] = 1'b0;
      bank_src[b]   = '0;
      for (int i = 0; i < NumGroups; i++) begin
        cand = ptr_q[b] + GroupIdxWidth'(i);
        if (!bank_gnt_o[b] && req_valid_i[cand] && (tgt[cand] == GroupIdxWidth'(b))) begin
          bank_gnt_o[b] = 1'b1;
          bank_src[b]   = cand;
        end
      end
      // Link code as in the xor group wiring
      bank_route_o[b] = bank_src[b] ^ GroupIdxWidth'(b);
    end
  end

  for (genvar p = 0; p < NumGroups; p++) begin : gen_ready
    assign req_ready_o[p] = req_valid_i[p] && bank_gnt_o[tgt[p]] &&
                            (bank_src[tgt[p]] == GroupIdxWidth'(p));
    assign resp_valid_o[p] = resp_pend_q[p] && resp_rd_q[p];
    assign resp_bank_o[p]  = resp_bank_q[p];
  end : gen_ready

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int b = 0; b < NumGroups; b++) begin
        ptr_q[b]       <= '0;
        resp_pend_q[b] <= 1'b0;
      end
    end else begin
      for (int b = 0; b < NumGroups; b++) begin
        // Winner drops to lowest priority
        if (bank_gnt_o[b]) begin
          ptr_q[b] <= GroupIdxWidth'(bank_src[b] + 1'b1);
        end
        resp_pend_q[b] <= req_ready_o[b];
      end
    end
  end

  // Response route, only meaningful while pending
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NumGroups; p++) begin
      if (req_ready_o[p]) begin
        resp_rd_q[p]   <= !req_wen_i[p];
        resp_bank_q[p] <= tgt[p];
      end
    end
  end

  for (genvar b = 0; b < NumGroups; b++) begin : gen_chk_bank
    for (genvar p = 0; p < NumGroups; p++) begin : gen_acc
      assign bank_acc[b][p] = req_ready_o[p] && (tgt[p] == GroupIdxWidth'(b));
    end : gen_acc

    // Only one port may be accepted into a bank per cycle
    a_one_per_bank: assert property (@(posedge clk_i) disable iff (rst_i)
      $onehot0(bank_acc[b]));
  end : gen_chk_bank

  for (genvar b = 0; b < NumGroups; b++) begin : gen_chk_route
    // Granted bank's route must lead back to an accepted port aimed at it
    a_route_match: assert property (@(posedge clk_i) disable iff (rst_i)
      bank_gnt_o[b] |-> req_ready_o[GroupIdxWidth'(b) ^ bank_route_o[b]] &&
        (tgt[GroupIdxWidth'(b) ^ bank_route_o[b]] == GroupIdxWidth'(b)));
  end : gen_chk_route

endmodule : tcdm_arbiter

// File: design/tcdm_bank.sv
// Single-port TCDM bank
// Write at the enabled edge, read data registered one cycle later

`timescale 1ns/1ps

module tcdm_bank
  import mempool_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 en_i,
  input  logic                 we_i,
  input  logic [RowWidth-1:0]  row_i,
  input  logic [DataWidth-1:0] wdata_i,
  output logic [DataWidth-1:0] rdata_o
);

  logic [DataWidth-1:0] mem [RowsPerBank];
  logic [DataWidth-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem[row_i] <= wdata_i;
      end else begin
        rdata_q <= mem[row_i];
      end
    end
  end

  // Held across writes so a pending response stays intact
  assign rdata_o = rdata_q;

  a_row_known: assert property (@(posedge clk_i)
    en_i |-> !$isunknown(row_i));

endmodule : tcdm_bank

// File: design/tcdm_req_xbar.sv
// Request crossbar
// Recovers each bank's granted source from the route code and steers that
// source's row, write enable and write data into the bank

`timescale 1ns/1ps

module tcdm_req_xbar
  import mempool_pkg::*;
(
  input  tcdm_addr_t               req_addr_i   [NumGroups],
  input  logic                     req_wen_i    [NumGroups],
  input  logic [DataWidth-1:0]     req_wdata_i  [NumGroups],
  input  logic                     bank_gnt_i   [NumGroups],
  input  logic [GroupIdxWidth-1:0] bank_route_i [NumGroups],
  output logic                     bank_en_o    [NumGroups],
  output logic                     bank_we_o    [NumGroups],
  output logic [RowWidth-1:0]      bank_row_o   [NumGroups],
  output logic [DataWidth-1:0]     bank_wdata_o [NumGroups]
);

  for (genvar b = 0; b < NumGroups; b++) begin : gen_bank
    logic [GroupIdxWidth-1:0] src;

    // Source group sits across the link named by the route
    assign src = GroupIdxWidth'(b) ^ bank_route_i[b];

    assign bank_en_o[b]    = bank_gnt_i[b];
    assign bank_we_o[b]    = req_wen_i[src];
    assign bank_row_o[b]   = req_addr_i[src].f.row;
    assign bank_wdata_o[b] = req_wdata_i[src];
  end : gen_bank

endmodule : tcdm_req_xbar

// File: design/tcdm_resp_xbar.sv
// Response crossbar
// Each port picks the read data of the bank that served it last cycle,
// so all four ports can receive data at once

`timescale 1ns/1ps

module tcdm_resp_xbar
  import mempool_pkg::*;
(
  input  logic [DataWidth-1:0]     bank_rdata_i [NumGroups],
  input  logic [GroupIdxWidth-1:0] resp_bank_i  [NumGroups],
  output logic [DataWidth-1:0]     resp_rdata_o [NumGroups]
);

  always_comb begin
    for (int p = 0; p < NumGroups; p++) begin
      resp_rdata_o[p] = bank_rdata_i[resp_bank_i[p]];
    end
  end

endmodule : tcdm_resp_xbar

// File: dv/tb_mempool_cluster.sv
// Testbench for the four-group TCDM cluster
// Drives all requester ports, keeps a reference memory and checks every
// response with concurrent assertions

`timescale 1ns/1ps

module tb_mempool_cluster
  import mempool_pkg::*;
;

  localparam int RandCycles = 300;
  localparam int FairCycles = 16;
  // Reset, route batches, parallel, fairness, handshake, random, margin
  localparam int MaxCycles  = 5 + 8 * 3 + 4 + FairCycles + 2 * 6 + RandCycles + 60;
  localparam logic [31:0] LfsrTaps = 32'h8020_0003;

  logic                 clk;
  logic                 rst;
  logic                 req_valid  [NumGroups];
  logic                 req_ready  [NumGroups];
  tcdm_addr_t           req_addr   [NumGroups];
  logic                 req_wen    [NumGroups];
  logic [DataWidth-1:0] req_wdata  [NumGroups];
  logic                 resp_valid [NumGroups];
  logic [DataWidth-1:0] resp_rdata [NumGroups];

  // Requests staged for the next batch
  logic                 pend_valid [NumGroups];
  tcdm_addr_t           pend_addr  [NumGroups];
  logic                 pend_wen   [NumGroups];
  logic [DataWidth-1:0] pend_wdata [NumGroups];

  // Reference model and per-port expectations
  logic [DataWidth-1:0] model_mem  [256];
  logic                 model_vld  [256];
  logic                 acc_q      [NumGroups];
  logic                 rd_acc_q   [NumGroups];
  logic [DataWidth-1:0] exp_rdata  [NumGroups];
  logic                 exp_known  [NumGroups];
  int                   wait_cnt   [NumGroups];
  logic [AddrWidth-1:0] route_addr [NumGroups][NumGroups];

  logic        par_chk;
  logic        fair_on;
  logic        fair_on_q;
  logic        fair_last_q;
  logic [31:0] lfsr_state = 32'hc755_7f75;
  string       test_name;
  int          value_errs;
  int          proto_errs;
  int          cycle_cnt;

  mempool_cluster dut0 (
    .clk_i       (clk       ),
    .rst_i       (rst       ),
    .req_valid_i (req_valid ),
    .req_ready_o (req_ready ),
    .req_addr_i  (req_addr  ),
    .req_wen_i   (req_wen   ),
    .req_wdata_i (req_wdata ),
    .resp_valid_o(resp_valid),
    .resp_rdata_o(resp_rdata)
  );

  always #10 clk = ~clk;

  // One bit per step, shifted right with feedback taps
  function automatic logic lfsr_step();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ LfsrTaps;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  // Model update and expected data at each accepting edge
  always @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < NumGroups; p++) begin
        acc_q[p]     <= 1'b0;
        rd_acc_q[p]  <= 1'b0;
        exp_known[p] <= 1'b0;
        wait_cnt[p]  <= 0;
      end
      for (int a = 0; a < 256; a++) begin
        model_vld[a] <= 1'b0;
      end
      fair_on_q <= 1'b0;
    end else begin
      for (int p = 0; p < NumGroups; p++) begin
        acc_q[p]    <= req_valid[p] && req_ready[p];
        rd_acc_q[p] <= req_valid[p] && req_ready[p] && !req_wen[p];
        wait_cnt[p] <= (req_valid[p] && !req_ready[p]) ? wait_cnt[p] + 1 : 0;
        if (req_valid[p] && req_ready[p]) begin
          if (req_wen[p]) begin
            model_mem[req_addr[p].word] <= req_wdata[p];
            model_vld[req_addr[p].word] <= 1'b1;
          end else begin
            exp_rdata[p] <= model_mem[req_addr[p].word];
            exp_known[p] <= model_vld[req_addr[p].word];
          end
        end
      end
      fair_on_q <= fair_on;
    end
    fair_last_q <= req_ready[1];
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      $display("Timeout: run did not finish within %0d cycles", MaxCycles);
      $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  for (genvar p = 0; p < NumGroups; p++) begin : gen_chk
    a_reset_quiet: assert property (@(posedge clk) rst |=> !resp_valid[p])
      else begin
        proto_errs++;
        $display("Port %0d raised a response during or right after reset", p);
      end

    // Response exactly one cycle after an accepted read, never after a write
    a_resp_timing: assert property (@(posedge clk) disable iff (rst)
      resp_valid[p] == rd_acc_q[p])
      else begin
        value_errs++;
        $display("FAILED %s port %0d resp_valid: expected %0b actual %0b", test_name, p,
                 $sampled(rd_acc_q[p]), $sampled(resp_valid[p]));
      end

    a_resp_data: assert property (@(posedge clk) disable iff (rst)
      (resp_valid[p] && exp_known[p]) |-> resp_rdata[p] == exp_rdata[p])
      else begin
        value_errs++;
        $display("FAILED %s port %0d rdata: expected %08h actual %08h", test_name, p,
                 $sampled(exp_rdata[p]), $sampled(resp_rdata[p]));
      end

    a_wait_bound: assert property (@(posedge clk) disable iff (rst)
      req_valid[p] |-> wait_cnt[p] < 4)
      else begin
        proto_errs++;
        $display("Port %0d waited more than four cycles for a grant", p);
      end
  end : gen_chk

  a_parallel: assert property (@(posedge clk) disable iff (rst)
    par_chk |-> (req_ready[0] && req_ready[1] && req_ready[2] && req_ready[3]))
    else begin
      proto_errs++;
      $display("Requests to four different banks were not all accepted together");
    end

  // Ports 1 and 3 share bank 2 and must take turns
  a_alternate: assert property (@(posedge clk) disable iff (rst)
    fair_on |-> (req_ready[1] != req_ready[3]) && (!fair_on_q || req_ready[1] != fair_last_q))
    else begin
      proto_errs++;
      $display("Grants to ports 1 and 3 on bank 2 did not alternate");
    end

  task automatic set_req(input int p, input logic [AddrWidth-1:0] addr, input logic wen,
                         input logic [DataWidth-1:0] wdata);
    pend_valid[p]     = 1'b1;
    pend_addr[p].word = addr;
    pend_wen[p]       = wen;
    pend_wdata[p]     = wdata;
  endtask

  // Drop accepted requests, hold the rest until all are taken
  task automatic drain_requests();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      par_chk = 1'b0;
      busy    = 1'b0;
      for (int p = 0; p < NumGroups; p++) begin
        if (acc_q[p]) begin
          req_valid[p] = 1'b0;
        end
        if (req_valid[p]) begin
          busy = 1'b1;
        end
      end
    end
  endtask

  task automatic send_pending(input bit check_par);
    @(negedge clk);
    for (int p = 0; p < NumGroups; p++) begin
      req_valid[p]  = pend_valid[p];
      req_addr[p]   = pend_addr[p];
      req_wen[p]    = pend_wen[p];
      req_wdata[p]  = pend_wdata[p];
      pend_valid[p] = 1'b0;
    end
    par_chk = check_par;
    drain_requests();
  endtask

  task automatic random_traffic(input int n);
    for (int c = 0; c < n; c++) begin
      @(negedge clk);
      for (int p = 0; p < NumGroups; p++) begin
        if (!req_valid[p] || acc_q[p]) begin
          req_valid[p]     = lfsr_step();
          req_wen[p]       = lfsr_step();
          req_addr[p].word = AddrWidth'(rand_bits(AddrWidth));
          req_wdata[p]     = rand_bits(DataWidth);
        end
      end
    end
    drain_requests();
  endtask

  initial begin
    int b;
    clk        = 1'b0;
    rst        = 1'b1;
    par_chk    = 1'b0;
    fair_on    = 1'b0;
    value_errs = 0;
    proto_errs = 0;
    cycle_cnt  = 0;
    test_name  = "reset";
    for (int p = 0; p < NumGroups; p++) begin
      req_valid[p]  = 1'b0;
      req_addr[p]   = '0;
      req_wen[p]    = 1'b0;
      req_wdata[p]  = '0;
      pend_valid[p] = 1'b0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Route r sends every port p to bank p ^ r, so no two ports collide
    test_name = "route";
    for (int r = 0; r < NumGroups; r++) begin
      for (int p = 0; p < NumGroups; p++) begin
        b = p ^ r;
        route_addr[p][b] = {RowWidth'(rand_bits(RowWidth)), GroupIdxWidth'(b)};
        set_req(p, route_addr[p][b], 1'b1, rand_bits(DataWidth));
      end
      send_pending(1'b0);
      for (int p = 0; p < NumGroups; p++) begin
        set_req(p, route_addr[p][p ^ r], 1'b0, '0);
      end
      send_pending(1'b0);
    end

    test_name = "parallel";
    for (int p = 0; p < NumGroups; p++) begin
      set_req(p, route_addr[p][(p + 1) % NumGroups], 1'b0, '0);
    end
    send_pending(1'b1);

    test_name = "fairness";
    @(negedge clk);
    req_valid[1]     = 1'b1;
    req_wen[1]       = 1'b0;
    req_addr[1].word = route_addr[1][2];
    req_valid[3]     = 1'b1;
    req_wen[3]       = 1'b0;
    req_addr[3].word = route_addr[3][2];
    fair_on          = 1'b1;
    repeat (FairCycles) @(negedge clk);
    fair_on      = 1'b0;
    req_valid[1] = 1'b0;
    req_valid[3] = 1'b0;

    // All ports write bank 0, losers hold until granted, then read back
    test_name = "handshake";
    for (int p = 0; p < NumGroups; p++) begin
      set_req(p, {RowWidth'(40 + p), GroupIdxWidth'(0)}, 1'b1, rand_bits(DataWidth));
    end
    send_pending(1'b0);
    for (int p = 0; p < NumGroups; p++) begin
      set_req(p, {RowWidth'(40 + p), GroupIdxWidth'(0)}, 1'b0, '0);
    end
    send_pending(1'b0);

    test_name = "random";
    random_traffic(RandCycles);
    repeat (3) @(negedge clk);

    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule : tb_mempool_cluster

// File: run.sh
#!/usr/bin/env bash
# Build and run the cluster testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module tb_mempool_cluster

./obj_dir/Vtb_mempool_cluster 2>&1 | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  echo "Result: pass"
else
  echo "Result: fail, see sim.log"
  exit 1
fi

// File: sources.f
design/mempool_pkg.sv
design/tcdm_arbiter.sv
design/tcdm_req_xbar.sv
design/tcdm_bank.sv
design/tcdm_resp_xbar.sv
design/mempool_cluster.sv
dv/tb_mempool_cluster.sv
